//--- files.f
+incdir+include
logic/laneExecPkg.sv
logic/stageBus.sv
logic/execStage1.sv
logic/execStage2.sv
logic/execStage3.sv
logic/laneExecTop.sv
test/laneExecChecker.sv
test/laneExecTb.sv

//--- Bender.yml
package:
  name: laneExec

export_include_dirs:
  - include

sources:
  - logic/laneExecPkg.sv
  - logic/stageBus.sv
  - logic/execStage1.sv
  - logic/execStage2.sv
  - logic/execStage3.sv
  - logic/laneExecTop.sv
  - target: test
    files:
      - test/laneExecChecker.sv
      - test/laneExecTb.sv

//--- test/laneExecTb.sv
/*
 Lane execute testbench
 Table driven issue stream, memory model with busy waits, and watchdog
*/
`timescale 1ns/100ps
`include "laneExec_config.svh"

module laneExecTb;
	import laneExecPkg::*;

	localparam int TABLE_LEN = 22;

	typedef struct {
		uCmd cmd;
		regId rm;
		logic [`DATA_WIDTH-1:0] rs;
		logic [`DATA_WIDTH-1:0] rt;
		logic [`DATA_WIDTH-1:0] rmVal;
		logic [`DATA_WIDTH-1:0] imm;
		int waitCycles;     // Busy cycles before memReady
		logic flush;
	} stimEntry;

	stimEntry stimTable [TABLE_LEN];

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic issueValid = 1'b0;
	uCmd issueCmd = cmdNop;
	regId issueIdRm = regZero;
	logic [`DATA_WIDTH-1:0] issueValRs = '0;
	logic [`DATA_WIDTH-1:0] issueValRt = '0;
	logic [`DATA_WIDTH-1:0] issueValRm = '0;
	logic [`DATA_WIDTH-1:0] issueImm = '0;
	logic flush = 1'b0;
	logic [`DATA_WIDTH-1:0] memDataIn = '0;
	memStatus memStatusIn = memIdle;
	int curWait = 0;
	logic done = 1'b0;
	logic issueHold, memReq, memWrite, wbValid, memFaultOut, reported;
	logic [`ADDR_WIDTH-1:0] memAddr;
	logic [`DATA_WIDTH-1:0] memStoreData, wbValue;
	regId wbId;
	int errors;
	int pending;

	// Memory model state
	logic [`DATA_WIDTH-1:0] memory [logic [`ADDR_WIDTH-1:0]];
	logic [`ADDR_WIDTH-1:0] pendAddr [$];
	logic pendWrite [$];
	logic [`DATA_WIDTH-1:0] pendData [$];
	int pendWait [$];
	int waitQueue [$];     // Waits of accepted memory ops, in order
	logic sawReq, sawWrite, sawDone, sawBusy, sawFault;
	logic [`ADDR_WIDTH-1:0] sawAddr;
	logic [`DATA_WIDTH-1:0] sawData;

	always #4 clock = ~clock;   // 8 ns period

	laneExecTop DUT (
		.clock(clock), .reset(reset), .issueValid(issueValid), .issueCmd(issueCmd),
		.issueIdRm(issueIdRm), .issueValRs(issueValRs), .issueValRt(issueValRt),
		.issueValRm(issueValRm), .issueImm(issueImm), .flush(flush),
		.memDataIn(memDataIn), .memStatus(memStatusIn), .issueHold(issueHold),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
		.memStoreData(memStoreData), .wbValid(wbValid), .wbId(wbId),
		.wbValue(wbValue), .memFault(memFaultOut)
	);

	laneExecChecker scoreboard (
		.clock(clock), .issueValid(issueValid), .issueHold(issueHold),
		.issueCmd(issueCmd), .issueIdRm(issueIdRm), .issueValRs(issueValRs),
		.issueValRt(issueValRt), .issueValRm(issueValRm), .issueImm(issueImm),
		.issueWait(curWait), .flush(flush), .memReq(memReq), .faultPulse(memFaultOut),
		.wbValid(wbValid), .wbId(wbId), .wbValue(wbValue), .done(done),
		.errors(errors), .pending(pending), .reported(reported)
	);

	function automatic logic [`DATA_WIDTH-1:0] rand64();
		return {$urandom, $urandom};
	endfunction

	// Untouched words carry their own address
	function automatic logic [`DATA_WIDTH-1:0] readWord(logic [`ADDR_WIDTH-1:0] a);
		return memory.exists(a) ? memory[a] : {~a[15:0], a};
	endfunction

	task automatic setEntry(int i, uCmd cmd, regId rm, logic [63:0] rs, logic [63:0] rt,
			logic [63:0] rmVal, logic [63:0] imm, int waitCycles, logic fl);
		stimTable[i] = '{cmd, rm, rs, rt, rmVal, imm, waitCycles, fl};
	endtask

	task automatic buildTable();
		setEntry(0, cmdAdd, 1, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(1, cmdSub, 2, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(2, cmdAnd, 3, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(3, cmdOr, 4, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(4, cmdXor, 5, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(5, cmdShl, 6, rand64(), 64'd13, 0, 0, 0, 0);
		setEntry(6, cmdMovImm, 7, 0, 0, 0, 64'h0123_4567_89AB_CDEF, 0, 0);
		setEntry(7, cmdLea, 8, 64'hFFFF_0000_0000_1000, 0, 0, 64'h20, 0, 0);  // Top bits cut
		setEntry(8, cmdAdd, regZero, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(9, cmdStore, 9, 64'h2000, 0, 64'hDEAD_BEEF_0123_4567, 64'h8,
			$urandom_range(4), 0);
		setEntry(10, cmdLoad, 10, 64'h2000, 0, 0, 64'h8, $urandom_range(4), 0);
		setEntry(11, cmdLoad, 11, 64'h3000, 0, 0, 0, 3, 0);      // Untouched address
		setEntry(12, cmdMul, 12, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(13, cmdAdd, 13, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(14, cmdSub, 14, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(15, cmdXor, 15, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(16, cmdOr, 16, rand64(), rand64(), 0, 0, 0, 1);   // Flush
		setEntry(17, cmdAdd, 17, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(18, cmdLoad, 18, 64'h2000, 0, 0, 64'h8, `MEM_HOLD_LIMIT + 5, 0);
		setEntry(19, cmdXor, 19, rand64(), rand64(), 0, 0, 0, 0);
		setEntry(20, cmdStore, 20, 64'h4000, 0, rand64(), 0, $urandom_range(4), 0);
		setEntry(21, cmdLoad, 21, 64'h4000, 0, 0, 0, $urandom_range(4), 0);
	endtask

	// Offer one entry until the lane takes it
	task automatic issueEntry(int i);
		issueValid = 1'b1;
		issueCmd = stimTable[i].cmd;
		issueIdRm = stimTable[i].rm;
		issueValRs = stimTable[i].rs;
		issueValRt = stimTable[i].rt;
		issueValRm = stimTable[i].rmVal;
		issueImm = stimTable[i].imm;
		curWait = stimTable[i].waitCycles;
		flush = stimTable[i].flush;
		do @(negedge clock); while (issueHold);
		if (isMemCmd(issueCmd) && !flush) waitQueue.push_back(curWait);
		@(posedge clock);
		#1;
	endtask

	// Sample memory side mid cycle
	always @(negedge clock) begin
		sawReq = memReq;
		sawWrite = memWrite;
		sawAddr = memAddr;
		sawData = memStoreData;
		sawFault = memFaultOut;
		sawDone = (memStatusIn == memReady) || memFaultOut;   // Head leaves EX3
		sawBusy = (memStatusIn == memBusy);
	end

	always @(posedge clock) begin
		#1;
		if (!reset) begin
			if (sawDone && pendAddr.size() != 0) begin
				if (pendWrite[0] && !sawFault) memory[pendAddr[0]] = pendData[0];
				void'(pendAddr.pop_front());
				void'(pendWrite.pop_front());
				void'(pendData.pop_front());
				void'(pendWait.pop_front());
			end else if (sawBusy) begin
				pendWait[0] = pendWait[0] - 1;
			end
			if (sawReq) begin
				pendAddr.push_back(sawAddr);
				pendWrite.push_back(sawWrite);
				pendData.push_back(sawData);
				pendWait.push_back(waitQueue.size() != 0 ? waitQueue.pop_front() : 0);
			end
		end
		// Status for the oldest request only
		if (pendAddr.size() == 0) begin
			memStatusIn = memIdle;
		end else if (pendWait[0] > 0) begin
			memStatusIn = memBusy;
		end else begin
			memStatusIn = memReady;
			memDataIn = readWord(pendAddr[0]);
		end
	end

	initial begin : stimulus
		int i;
		void'($urandom(32'h0135_03d4));
		buildTable();
		repeat (16) @(posedge clock);
		#1 reset = 1'b0;
		for (i = 0; i < TABLE_LEN; i++) issueEntry(i);
		issueValid = 1'b0;
		flush = 1'b0;
		while (pending != 0 || pendAddr.size() != 0) @(negedge clock);
		repeat (4) @(negedge clock);
		done = 1'b1;
		wait (reported);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Worst case every entry runs into the hold limit
	initial begin : watchdog
		repeat (16 + TABLE_LEN * (`MEM_HOLD_LIMIT + 8)) @(posedge clock);
		$display("Timeout: lane did not drain, %0d writebacks still outstanding", pending);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- test/laneExecChecker.sv
/*
 Lane execute checker
 Predicts writebacks from accepted issues and compares them in order
*/
`timescale 1ns/100ps
`include "laneExec_config.svh"

module laneExecChecker (
	input logic clock,
	input logic issueValid,
	input logic issueHold,
	input laneExecPkg::uCmd issueCmd,
	input laneExecPkg::regId issueIdRm,
	input logic [`DATA_WIDTH-1:0] issueValRs,
	input logic [`DATA_WIDTH-1:0] issueValRt,
	input logic [`DATA_WIDTH-1:0] issueValRm,
	input logic [`DATA_WIDTH-1:0] issueImm,
	input int issueWait,
	input logic flush,
	input logic memReq,
	input logic faultPulse,
	input logic wbValid,
	input laneExecPkg::regId wbId,
	input logic [`DATA_WIDTH-1:0] wbValue,
	input logic done,
	output int errors = 0,
	output int pending,
	output logic reported = 1'b0
);
	import laneExecPkg::*;

	logic [`DATA_WIDTH-1:0] mirror [logic [`ADDR_WIDTH-1:0]];   // Memory as seen by stores
	regId expId [$];
	logic [`DATA_WIDTH-1:0] expVal [$];
	int expTest [$];
	int testNum = 0;
	int passCount = 0;
	int reqCount = 0;
	int expReq = 0;
	int faultCount = 0;
	int expFault = 0;
	int holdCount = 0;
	int expHold = 0;           // Busy cycles, capped at the limit
	logic holdBefore = 1'b0;   // Hold at the last edge

	assign pending = expId.size();

	always @(negedge clock) begin : watch
		logic [`DATA_WIDTH-1:0] sum;
		logic [`ADDR_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] v;
		logic writes;
		// Fresh writeback only when the last edge was not held
		if (wbValid && !holdBefore) begin
			if (expId.size() == 0) begin
				errors++;
				$display("FAIL %0t: writeback r%0d = %h with none expected", $time, wbId, wbValue);
			end else begin
				if (wbId === expId[0] && wbValue === expVal[0]) begin
					passCount++;
					$display("test %0d: r%0d = %h ok", expTest[0], wbId, wbValue);
				end else begin
					errors++;
					$display("FAIL %0t: test %0d wrote r%0d = %h, expected r%0d = %h", $time,
						expTest[0], wbId, wbValue, expId[0], expVal[0]);
				end
				void'(expId.pop_front());
				void'(expVal.pop_front());
				void'(expTest.pop_front());
			end
		end
		if (memReq) reqCount++;
		if (faultPulse) faultCount++;
		if (issueHold) holdCount++;
		// Everything still in flight dies
		while (flush && expId.size() != 0) begin
			$display("test %0d: squashed by flush", expTest[0]);
			void'(expId.pop_front());
			void'(expVal.pop_front());
			void'(expTest.pop_front());
		end
		if (issueValid && !issueHold) begin
			testNum++;
			sum = issueValRs + issueImm;
			a = sum[`ADDR_WIDTH-1:0];
			writes = 1'b1;
			v = '0;
			case (issueCmd)
				cmdAdd: v = issueValRs + issueValRt;
				cmdSub: v = issueValRs - issueValRt;
				cmdAnd: v = issueValRs & issueValRt;
				cmdOr: v = issueValRs | issueValRt;
				cmdXor: v = issueValRs ^ issueValRt;
				cmdShl: v = issueValRs << issueValRt[5:0];
				cmdMovImm: v = issueImm;
				cmdLea: v = `DATA_WIDTH'(a);
				cmdMul: v = issueValRs * issueValRt;   // Low half
				cmdLoad: begin
					expReq++;
					expHold += (issueWait > `MEM_HOLD_LIMIT) ? `MEM_HOLD_LIMIT : issueWait;
					v = mirror.exists(a) ? mirror[a] : {~a[15:0], a};
					if (issueWait > `MEM_HOLD_LIMIT) begin
						writes = 1'b0;
						expFault++;
					end
				end
				cmdStore: begin
					expReq++;
					expHold += (issueWait > `MEM_HOLD_LIMIT) ? `MEM_HOLD_LIMIT : issueWait;
					mirror[a] = issueValRm;
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && !flush && issueIdRm != regZero) begin
				expId.push_back(issueIdRm);
				expVal.push_back(v);
				expTest.push_back(testNum);
			end else begin
				$display("test %0d: no writeback expected", testNum);
			end
		end
		holdBefore = issueHold;
		if (done && !reported) begin
			if (expId.size() != 0) begin
				errors++;
				$display("Lost writebacks: %0d predicted results never arrived", expId.size());
			end
			if (reqCount != expReq) begin
				errors++;
				$display("FAIL %0t: %0d memory requests, expected %0d", $time, reqCount, expReq);
			end
			if (faultCount != expFault) begin
				errors++;
				$display("FAIL %0t: %0d fault pulses, expected %0d", $time, faultCount, expFault);
			end
			if (holdCount != expHold) begin
				errors++;
				$display("FAIL %0t: %0d hold cycles, expected %0d", $time, holdCount, expHold);
			end
			$display("Tests %0d, writebacks ok %0d, errors %0d", testNum, passCount, errors);
			reported = 1'b1;
		end
	end

endmodule

//--- logic/laneExecTop.sv
/*
 Lane 1 execute pipeline
 EX1 to EX3 with a registered writeback port
*/
`timescale 1ns/100ps
`include "laneExec_config.svh"

module laneExecTop (
	input logic clock,
	input logic reset,
	input logic issueValid,
	input laneExecPkg::uCmd issueCmd,
	input laneExecPkg::regId issueIdRm,
	input logic [`DATA_WIDTH-1:0] issueValRs,
	input logic [`DATA_WIDTH-1:0] issueValRt,
	input logic [`DATA_WIDTH-1:0] issueValRm,
	input logic [`DATA_WIDTH-1:0] issueImm,
	input logic flush,
	input logic [`DATA_WIDTH-1:0] memDataIn,
	input laneExecPkg::memStatus memStatus,
	output logic issueHold,
	output logic memReq,
	output logic memWrite,
	output logic [`ADDR_WIDTH-1:0] memAddr,
	output logic [`DATA_WIDTH-1:0] memStoreData,
	output logic wbValid,
	output laneExecPkg::regId wbId,
	output logic [`DATA_WIDTH-1:0] wbValue,
	output logic memFault
);
	import laneExecPkg::*;

	logic hold;        // Lane freeze from EX3
	logic resValid;
	regId resId;
	logic [`DATA_WIDTH-1:0] resValue;

	stageBus ex1ToEx2 ();
	stageBus ex2ToEx3 ();

	execStage1 ex1 (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.flush(flush),
		.issueValid(issueValid),
		.issueCmd(issueCmd),
		.issueIdRm(issueIdRm),
		.issueValRs(issueValRs),
		.issueValRt(issueValRt),
		.issueImm(issueImm),
		.issueValRm(issueValRm),
		.toEx2(ex1ToEx2)
	);

	execStage2 ex2 (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.flush(flush),
		.fromEx1(ex1ToEx2),
		.toEx3(ex2ToEx3),
		.memReq(memReq),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memStoreData(memStoreData)
	);

	execStage3 ex3 (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.memStatus(memStatus),
		.memDataIn(memDataIn),
		.fromEx2(ex2ToEx3),
		.hold(hold),
		.resValid(resValid),
		.resId(resId),
		.resValue(resValue),
		.memFault(memFault)
	);

	// Issuer keeps its op while the lane is frozen
	assign issueHold = hold;

	// Writeback register
	always_ff @(posedge clock) begin
		if (reset) begin
			wbValid <= 1'b0;
		end else if (!hold) begin
			wbValid <= resValid;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			wbId <= resId;
			wbValue <= resValue;
		end
	end

endmodule

//--- logic/execStage3.sv
/*
 EX3 stage
 Final result select, flush squash, memory hold and hold timeout
*/
`timescale 1ns/100ps
`include "laneExec_config.svh"

module execStage3 (
	input logic clock,
	input logic reset,
	input logic flush,
	input laneExecPkg::memStatus memStatus,
	input logic [`DATA_WIDTH-1:0] memDataIn,
	stageBus.sink fromEx2,
	output logic hold,
	output logic resValid,
	output laneExecPkg::regId resId,
	output logic [`DATA_WIDTH-1:0] resValue,
	output logic memFault
);
	import laneExecPkg::*;

	localparam int HOLD_CNT_WIDTH = $clog2(`MEM_HOLD_LIMIT + 1);

	logic memOp;
	logic memWaiting;
	logic holdTimeout;
	logic opFailed;
	logic [HOLD_CNT_WIDTH-1:0] holdCycles;   // Cycles held so far

	assign memOp = fromEx2.valid && isMemCmd(fromEx2.cmd);
	assign memWaiting = memOp && (memStatus == memBusy);

	// Limit reached and memory still busy
	assign holdTimeout = (holdCycles == HOLD_CNT_WIDTH'(`MEM_HOLD_LIMIT));

	// Flush always releases the lane
	assign hold = memWaiting && !holdTimeout && !flush;

	// Port shadows the enum member, hence the package prefix
	assign opFailed = memOp && ((memStatus == laneExecPkg::memFault) ||
		(memWaiting && holdTimeout));
	assign memFault = opFailed && !flush;   // Single cycle, op completes

	always_comb begin
		resId = fromEx2.idRn;     // Forward EX1 result by default
		resValue = fromEx2.valRn;
		case (fromEx2.cmd)
			cmdLoad: begin
				resId = fromEx2.idRm;
				resValue = memDataIn;
			end
			cmdMul: begin
				resId = fromEx2.idRm;
				resValue = fromEx2.mulRes;
			end
			cmdStore: resId = regZero;   // Nothing to write back
			default: begin
			end
		endcase

		// Squashed or failed ops go to the discard register
		if (opFailed || flush) begin
			resId = regZero;
		end
		resValid = fromEx2.valid && (resId != regZero);
	end

	// Saturating hold counter
	always_ff @(posedge clock) begin
		if (reset) begin
			holdCycles <= '0;
		end else if (!hold) begin
			holdCycles <= '0;
		end else if (!holdTimeout) begin
			holdCycles <= holdCycles + 1'b1;
		end
	end

	// Hold only for a memory op, which then stays parked in EX3
	holdParksMemOp: assert property (@(posedge clock) disable iff (reset)
		hold |-> memOp ##1 (memOp && $stable(fromEx2.cmd) && $stable(fromEx2.idRm)));

	// Unhandled commands
	cmdKnown: assert property (@(posedge clock) disable iff (reset)
		fromEx2.valid |-> fromEx2.cmd inside {cmdNop, cmdAdd, cmdSub, cmdAnd,
			cmdOr, cmdXor, cmdShl, cmdMovImm, cmdLea, cmdLoad, cmdStore, cmdMul});

endmodule

//--- logic/execStage2.sv
/*
 EX2 stage
 Memory request issue and multiply, feeding the EX2 register
*/
`timescale 1ns/100ps
`include "laneExec_config.svh"

module execStage2 (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic flush,
	stageBus.sink fromEx1,
	stageBus.source toEx3,
	output logic memReq,
	output logic memWrite,
	output logic [`ADDR_WIDTH-1:0] memAddr,
	output logic [`DATA_WIDTH-1:0] memStoreData
);
	import laneExecPkg::*;

	logic reqIssued;     // Request already sent for the held op
	logic [`DATA_WIDTH-1:0] productLow;

	// Low half of the product only
	assign productLow = fromEx1.mulA * fromEx1.mulB;

	// One request per op, none for an op being flushed
	assign memReq = fromEx1.valid && isMemCmd(fromEx1.cmd) && !reqIssued && !flush;
	assign memWrite = (fromEx1.cmd == cmdStore);
	assign memAddr = fromEx1.addr;
	assign memStoreData = fromEx1.storeData;

	always_ff @(posedge clock) begin
		if (reset) begin
			reqIssued <= 1'b0;
		end else if (flush || !hold) begin
			reqIssued <= 1'b0;   // Op moves on or dies
		end else if (memReq) begin
			reqIssued <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			toEx3.valid <= 1'b0;
		end else if (flush) begin
			toEx3.valid <= 1'b0;
		end else if (!hold) begin
			toEx3.valid <= fromEx1.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			toEx3.cmd <= fromEx1.cmd;
			toEx3.idRn <= fromEx1.idRn;
			toEx3.valRn <= fromEx1.valRn;
			toEx3.idRm <= fromEx1.idRm;
			toEx3.addr <= fromEx1.addr;
			toEx3.storeData <= fromEx1.storeData;
			toEx3.mulRes <= productLow;
		end
	end

	// Operands are consumed here
	assign toEx3.mulA = '0;
	assign toEx3.mulB = '0;

	// Flagged op stays parked in the EX1 register and never asks memory again
	singleRequest: assert property (@(posedge clock) disable iff (reset)
		reqIssued |-> (!memReq && fromEx1.valid && isMemCmd(fromEx1.cmd) &&
			$stable(fromEx1.addr)));

endmodule

//--- logic/execStage1.sv
/*
 EX1 stage
 ALU, immediate move and address generation into the EX1 register
*/
`timescale 1ns/100ps
`include "laneExec_config.svh"

module execStage1 (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic flush,
	input logic issueValid,
	input laneExecPkg::uCmd issueCmd,
	input laneExecPkg::regId issueIdRm,
	input logic [`DATA_WIDTH-1:0] issueValRs,
	input logic [`DATA_WIDTH-1:0] issueValRt,
	input logic [`DATA_WIDTH-1:0] issueImm,
	input logic [`DATA_WIDTH-1:0] issueValRm,
	stageBus.source toEx2
);
	import laneExecPkg::*;

	localparam int SHIFT_WIDTH = $clog2(`DATA_WIDTH);

	logic [`DATA_WIDTH-1:0] addrSum;
	logic [`ADDR_WIDTH-1:0] addrNext;
	regId idRnNext;
	logic [`DATA_WIDTH-1:0] valRnNext;

	// Base plus displacement, truncated to the bus
	assign addrSum = issueValRs + issueImm;
	assign addrNext = addrSum[`ADDR_WIDTH-1:0];

	always_comb begin
		idRnNext = issueIdRm;    // Rm is the ALU destination
		valRnNext = '0;
		case (issueCmd)
			cmdAdd: valRnNext = issueValRs + issueValRt;
			cmdSub: valRnNext = issueValRs - issueValRt;
			cmdAnd: valRnNext = issueValRs & issueValRt;
			cmdOr: valRnNext = issueValRs | issueValRt;
			cmdXor: valRnNext = issueValRs ^ issueValRt;
			cmdShl: valRnNext = issueValRs << issueValRt[SHIFT_WIDTH-1:0];
			cmdMovImm: valRnNext = issueImm;
			// Address written back zero extended
			cmdLea: valRnNext = {{(`DATA_WIDTH - `ADDR_WIDTH){1'b0}}, addrNext};
			default: begin
				// Load, store, mul and nop produce nothing here
				idRnNext = regZero;
			end
		endcase
	end

	// Flush drops the issue of the same cycle too
	always_ff @(posedge clock) begin
		if (reset) begin
			toEx2.valid <= 1'b0;
		end else if (flush) begin
			toEx2.valid <= 1'b0;
		end else if (!hold) begin
			toEx2.valid <= issueValid;
		end
	end

	// Payload register
	always_ff @(posedge clock) begin
		if (!hold) begin
			toEx2.cmd <= issueCmd;
			toEx2.idRn <= idRnNext;
			toEx2.valRn <= valRnNext;
			toEx2.idRm <= issueIdRm;       // Load / mul target
			toEx2.addr <= addrNext;
			toEx2.storeData <= issueValRm;   // Store source is Rm
			toEx2.mulA <= issueValRs;
			toEx2.mulB <= issueValRt;
		end
	end

	// Product only exists after EX2
	assign toEx2.mulRes = '0;

endmodule

//--- logic/stageBus.sv
/*
 Stage bus
 One operation passed from an execute stage register to the next stage
*/
`timescale 1ns/100ps
`include "laneExec_config.svh"

interface stageBus;
	import laneExecPkg::*;

	logic valid;                         // Operation present
	uCmd cmd;
	regId idRn;                          // Destination so far
	logic [`DATA_WIDTH-1:0] valRn;       // Value so far
	regId idRm;                          // Load / multiply destination
	logic [`ADDR_WIDTH-1:0] addr;
	logic [`DATA_WIDTH-1:0] storeData;
	logic [`DATA_WIDTH-1:0] mulA;        // Multiply operands, EX1 to EX2
	logic [`DATA_WIDTH-1:0] mulB;
	logic [`DATA_WIDTH-1:0] mulRes;      // Product, EX2 to EX3

	// Earlier stage register drives
	modport source (
		output valid, cmd, idRn, valRn, idRm, addr, storeData,
		output mulA, mulB, mulRes
	);

	// Later stage reads
	modport sink (
		input valid, cmd, idRn, valRn, idRm, addr, storeData,
		input mulA, mulB, mulRes
	);

endinterface

//--- logic/laneExecPkg.sv
/*
 Lane execute types
 Microcode commands, memory return status and register ids
*/
`include "laneExec_config.svh"

package laneExecPkg;

	// Microcode command for lane 1
	typedef enum logic [3:0] {
		cmdNop    = 4'h0,
		cmdAdd    = 4'h1,
		cmdSub    = 4'h2,
		cmdAnd    = 4'h3,
		cmdOr     = 4'h4,
		cmdXor    = 4'h5,
		cmdShl    = 4'h6,
		cmdMovImm = 4'h7,
		cmdLea    = 4'h8,
		cmdLoad   = 4'h9,
		cmdStore  = 4'hA,
		cmdMul    = 4'hB
	} uCmd;

	// Status on the memory data return
	typedef enum logic [1:0] {
		memIdle  = 2'b00,
		memReady = 2'b01,
		memBusy  = 2'b10,
		memFault = 2'b11
	} memStatus;

	typedef logic [`REG_ID_WIDTH-1:0] regId;

	// Discard register, never written back
	localparam regId regZero = '0;

	// Commands that talk to memory
	function automatic logic isMemCmd(uCmd cmd);
		return (cmd == cmdLoad) || (cmd == cmdStore);
	endfunction

endpackage

//--- include/laneExec_config.svh
/*
 Lane execute configuration
 Datapath widths and the memory hold limit
*/
`ifndef LANE_EXEC_CONFIG_SVH
`define LANE_EXEC_CONFIG_SVH

// Operand and result width
`define DATA_WIDTH 64

// Memory address width
`define ADDR_WIDTH 48

// Register identifier width
`define REG_ID_WIDTH 6

// Longest memory hold in cycles before it counts as a fault
`define MEM_HOLD_LIMIT 15

`endif
